// File: Makefile
VERILATOR ?= verilator
TOP := l2_tb
FILELIST := filelist.f
FLAGS := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// File: dv/l2_checker.sv
`default_nettype none

module l2_checker (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic i_req,
	input wire logic d_req,
	input wire logic i_resp,
	input wire logic d_resp,
	input wire logic pmem_read,
	input wire logic pmem_write
);

	logic i_open;
	logic d_open;

	// open from a port's strobe until its response.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			i_open <= 1'b0;
			d_open <= 1'b0;
		end else begin
			if (i_req)
				i_open <= 1'b1;
			else if (i_resp)
				i_open <= 1'b0;
			if (d_req)
				d_open <= 1'b1;
			else if (d_resp)
				d_open <= 1'b0;
		end
	end

	resp_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!(i_resp && d_resp))
		else $error("i_resp and d_resp high in the same cycle");

	pmem_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!(pmem_read && pmem_write))
		else $error("pmem_read and pmem_write high in the same cycle");

	i_resp_requested: assert property (@(posedge clk) disable iff (!arst_n)
		i_resp |-> i_open)
		else $error("i_resp without an open request on the i port");

	d_resp_requested: assert property (@(posedge clk) disable iff (!arst_n)
		d_resp |-> d_open)
		else $error("d_resp without an open request on the d port");

endmodule : l2_checker

`default_nettype wire

// File: dv/l2_tb.sv
`default_nettype none

`include "l2_defs.svh"

module l2_tb import lc3b_types::*; ();

	// one entry per line of the 16-bit address space.
	localparam int lines = 1 << (`L2_TAG_HI - `L2_INDEX_LO + 1);
	// about 600 operations, up to 20 cycles each, doubled for contention.
	localparam int max_cycles = 30000;

	logic clk;
	logic arst_n;
	logic i_req;
	logic i_write;
	lc3b_word i_address;
	lc3b_burst i_wdata;
	logic i_resp;
	lc3b_burst i_rdata;
	logic d_req;
	logic d_write;
	lc3b_word d_address;
	lc3b_burst d_wdata;
	logic d_resp;
	lc3b_burst d_rdata;
	logic pmem_read;
	logic pmem_write;
	lc3b_word pmem_address;
	lc3b_burst pmem_wdata;
	lc3b_burst pmem_rdata = '0;
	logic pmem_resp = 1'b0;

	lc3b_burst mem [lines];
	lc3b_burst shadow [lines];
	int reads = 0;
	int writes = 0;
	int cycles = 0;
	lc3b_word last_wb_addr = '0;
	logic passed = 1'b0;
	logic fail_shown = 1'b0;

	l2_subsystem dut0 (
		.clk(clk), .arst_n(arst_n),
		.i_req(i_req), .i_write(i_write), .i_address(i_address), .i_wdata(i_wdata),
		.i_resp(i_resp), .i_rdata(i_rdata),
		.d_req(d_req), .d_write(d_write), .d_address(d_address), .d_wdata(d_wdata),
		.d_resp(d_resp), .d_rdata(d_rdata),
		.pmem_read(pmem_read), .pmem_write(pmem_write), .pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata), .pmem_rdata(pmem_rdata), .pmem_resp(pmem_resp)
	);

	bind l2_subsystem l2_checker checker0 (
		.clk(clk), .arst_n(arst_n), .i_req(i_req), .d_req(d_req),
		.i_resp(i_resp), .d_resp(d_resp),
		.pmem_read(pmem_read), .pmem_write(pmem_write)
	);

	// latest line contents as the requesters see them.
	function automatic lc3b_burst expected_line(input lc3b_word addr);
		return shadow[addr[`L2_TAG_HI:`L2_INDEX_LO]];
	endfunction

	function automatic lc3b_burst random_line();
		lc3b_burst v;
		for (int w = 0; w < 8; w++)
			v[w*32 +: 32] = $urandom;
		return v;
	endfunction

	function automatic void show_fail();
		$display("TEST FAILED");
		fail_shown = 1'b1;
	endfunction

	function automatic void stop_run(input string why);
		$display("%s", why);
		show_fail();
		$fatal(1, "simulation stopped on first error");
	endfunction

	// writes land in the shadow in the order the l2 serves them.
	function automatic void check_response(input string name, input logic wr,
			input lc3b_word addr, input lc3b_burst wdata, input lc3b_burst rdata);
		if (wr)
			shadow[addr[`L2_TAG_HI:`L2_INDEX_LO]] = wdata;
		else
			assert (rdata == expected_line(addr))
				else stop_run($sformatf("MISMATCH %s expected %h got %h",
					name, expected_line(addr), rdata));
	endfunction

	task automatic access(input logic on_d, input logic wr, input lc3b_word addr,
			input lc3b_burst data, output int latency);
		latency = 0;
		if (on_d) begin
			d_write = wr;
			d_address = addr;
			d_wdata = data;
			d_req = 1'b1;
		end else begin
			i_write = wr;
			i_address = addr;
			i_wdata = data;
			i_req = 1'b1;
		end
		@(posedge clk);
		#1;
		if (on_d)
			d_req = 1'b0;
		else
			i_req = 1'b0;
		do begin
			@(posedge clk);
			latency++;
		end while (!(on_d ? d_resp : i_resp));
		#1;
	endtask

	// four tags over sets 8 to 11, so evictions are frequent.
	task automatic random_ops(input logic on_d, input int count);
		lc3b_word addr;
		logic wr;
		int lat;
		for (int n = 0; n < count; n++) begin
			addr = {4'b0000, 2'($urandom_range(3)), 3'b010, 2'($urandom_range(3)),
				5'($urandom_range(31))};
			wr = 1'($urandom_range(1));
			access(on_d, wr, addr, random_line(), lat);
			repeat (int'($urandom_range(2))) begin
				@(posedge clk);
				#1;
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles)
			stop_run("timeout: the test did not finish within the cycle limit");
	end

	// physical memory, one access at a time, answered 5 cycles after the strobe.
	always begin : memory_model
		lc3b_word addr;
		lc3b_burst data;
		logic is_write;
		@(posedge clk);
		if (arst_n && (pmem_read || pmem_write)) begin
			addr = pmem_address;
			data = pmem_wdata;
			is_write = pmem_write;
			repeat (4) @(posedge clk);
			#1;
			if (is_write) begin
				assert (data == expected_line(addr))
					else stop_run($sformatf("MISMATCH pmem_wdata expected %h got %h",
						expected_line(addr), data));
				mem[addr[`L2_TAG_HI:`L2_INDEX_LO]] = data;
				last_wb_addr = addr;
				writes++;
			end else begin
				// a line outside the cache is current in memory.
				assert (mem[addr[`L2_TAG_HI:`L2_INDEX_LO]] == expected_line(addr))
					else stop_run($sformatf("MISMATCH pmem_rdata expected %h got %h",
						expected_line(addr), mem[addr[`L2_TAG_HI:`L2_INDEX_LO]]));
				pmem_rdata = mem[addr[`L2_TAG_HI:`L2_INDEX_LO]];
				reads++;
			end
			pmem_resp = 1'b1;
			@(posedge clk);
			#1;
			pmem_resp = 1'b0;
		end
	end

	always @(posedge clk) begin
		if (i_resp)
			check_response("i_rdata", i_write, i_address, i_wdata, i_rdata);
		if (d_resp)
			check_response("d_rdata", d_write, d_address, d_wdata, d_rdata);
	end

	initial begin : stimulus
		int lat;
		int lat_d;
		int r0;
		int w0;
		void'($urandom(75815));
		arst_n = 1'b0;
		i_req = 1'b0;
		i_write = 1'b0;
		i_address = '0;
		i_wdata = '0;
		d_req = 1'b0;
		d_write = 1'b0;
		d_address = '0;
		d_wdata = '0;
		for (int n = 0; n < lines; n++) begin
			mem[n] = random_line();
			shadow[n] = mem[n];
		end
		repeat (4) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(posedge clk);
		#1;

		// read miss, then the same line again as a hit.
		r0 = reads;
		w0 = writes;
		access(1'b0, 1'b0, 16'h0024, '0, lat);
		assert (reads == r0 + 1 && writes == w0)
			else stop_run("read miss did not cause exactly one memory read");
		access(1'b1, 1'b0, 16'h0024, '0, lat);
		assert (reads == r0 + 1 && writes == w0)
			else stop_run("read hit touched physical memory");
		assert (lat == 3)
			else stop_run($sformatf("hit answered after %0d cycles instead of 3", lat));

		// write then read back.
		access(1'b0, 1'b1, 16'h0028, random_line(), lat);
		access(1'b1, 1'b0, 16'h0020, '0, lat);

		// three tags in set 2, the first one written is the victim.
		access(1'b1, 1'b1, 16'h0040, random_line(), lat);
		access(1'b0, 1'b1, 16'h0440, random_line(), lat);
		w0 = writes;
		access(1'b1, 1'b1, 16'h0840, random_line(), lat);
		assert (writes == w0 + 1 && last_wb_addr == 16'h0040)
			else stop_run("dirty eviction did not write back the least recently used line");
		access(1'b0, 1'b0, 16'h0040, '0, lat);

		// same-cycle strobes on both ports.
		fork
			access(1'b0, 1'b0, 16'h0024, '0, lat);
			access(1'b1, 1'b0, 16'h0840, '0, lat_d);
		join
		// d wins the tie as i was served last.
		assert (lat_d == 3 && lat == 6)
			else stop_run($sformatf("contention latencies i %0d d %0d instead of 6 and 3",
				lat, lat_d));

		fork
			random_ops(1'b0, 250);
			random_ops(1'b1, 250);
		join

		passed = 1'b1;
		$display("TEST PASSED");
		$finish;
	end

	final begin
		if (!passed && !fail_shown)
			show_fail();
	end

endmodule : l2_tb

`default_nettype wire

// File: filelist.f
+incdir+hdl
hdl/lc3b_types.sv
hdl/l2_way_array.sv
hdl/cache_datapath_l2.sv
hdl/cache_control_l2.sv
hdl/l2_port_arbiter.sv
hdl/l2_subsystem.sv
dv/l2_checker.sv
dv/l2_tb.sv

// File: hdl/cache_control_l2.sv
`default_nettype none

module cache_control_l2 import lc3b_types::*; (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic l2_req,
	input wire logic l2_write,
	input wire logic tag_hit,
	input wire logic valid,
	input wire logic dirty,
	input wire logic pmem_resp,
	output logic l2_resp,
	output logic pmem_read,
	output logic pmem_write,
	output logic load_data,
	output logic load_tag,
	output logic load_valid,
	output logic load_dirty,
	output logic clear_dirty,
	output logic load_lru,
	output logic cache_in_sel,
	output logic pmem_addr_sel
);

	typedef enum logic [1:0] {
		s_idle,
		s_compare,
		s_writeback,
		s_allocate
	} state_t;

	state_t state;
	state_t next_state;
	logic issued;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= s_idle;
			issued <= 1'b0;
		end else begin
			state <= next_state;
			// one memory strobe per writeback or allocate visit.
			if (pmem_resp)
				issued <= 1'b0;
			else if (pmem_read || pmem_write)
				issued <= 1'b1;
		end
	end

	always_comb begin
		next_state = state;
		l2_resp = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		load_data = 1'b0;
		load_tag = 1'b0;
		load_valid = 1'b0;
		load_dirty = 1'b0;
		clear_dirty = 1'b0;
		load_lru = 1'b0;
		cache_in_sel = 1'b0;
		pmem_addr_sel = 1'b0;
		unique case (state)
			s_idle: begin
				if (l2_req)
					next_state = s_compare;
			end
			s_compare: begin
				if (tag_hit) begin
					l2_resp = 1'b1;
					load_lru = 1'b1;
					if (l2_write) begin
						load_data = 1'b1;
						cache_in_sel = 1'b1;
						load_dirty = 1'b1;
					end
					next_state = s_idle;
				end else if (valid && dirty) begin
					next_state = s_writeback;
				end else begin
					next_state = s_allocate;
				end
			end
			s_writeback: begin
				pmem_addr_sel = 1'b1;
				pmem_write = !issued;
				if (pmem_resp)
					next_state = s_allocate;
			end
			s_allocate: begin
				pmem_read = !issued;
				if (pmem_resp) begin
					load_data = 1'b1;
					load_tag = 1'b1;
					load_valid = 1'b1;
					clear_dirty = 1'b1;
					next_state = s_compare;
				end
			end
			default: next_state = s_idle;
		endcase
	end

endmodule : cache_control_l2

`default_nettype wire

// File: hdl/cache_datapath_l2.sv
`default_nettype none

`include "l2_defs.svh"

module cache_datapath_l2 import lc3b_types::*; (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic load_data,
	input wire logic load_valid,
	input wire logic load_dirty,
	input wire logic clear_dirty,
	input wire logic load_lru,
	input wire logic load_tag,
	input wire logic cache_in_sel,
	input wire logic pmem_addr_sel,
	input wire lc3b_word mem_address,
	input wire lc3b_burst mem_wdata,
	input wire lc3b_burst pmem_rdata,
	output logic tag_hit,
	output logic valid,
	output logic dirty,
	output lc3b_burst mem_rdata,
	output lc3b_burst pmem_wdata,
	output lc3b_word pmem_address
);

	localparam int offset_bits = `L2_OFFSET_HI - `L2_OFFSET_LO + 1;

	lc3b_set_l2 set;
	lc3b_tag_l2 tag;
	lc3b_tag_l2 tag0;
	lc3b_tag_l2 tag1;
	lc3b_tag_l2 victim_tag;
	lc3b_burst line0;
	lc3b_burst line1;
	lc3b_burst line_out;
	lc3b_burst fill_data;
	logic valid0;
	logic valid1;
	logic dirty0;
	logic dirty1;
	logic hit0;
	logic hit1;
	logic way_sel;
	logic lru [`L2_SETS];

	assign set = mem_address[`L2_INDEX_HI:`L2_INDEX_LO];
	assign tag = mem_address[`L2_TAG_HI:`L2_TAG_LO];

	assign hit0 = valid0 && (tag0 == tag);
	assign hit1 = valid1 && (tag1 == tag);
	assign tag_hit = hit0 || hit1;

	// hit way when there is one, else the lru victim.
	assign way_sel = tag_hit ? hit1 : lru[set];

	// 0 fills from memory, 1 takes the requester line.
	assign fill_data = cache_in_sel ? mem_wdata : pmem_rdata;

	l2_way_array #(.payload_t(lc3b_burst)) data_array (
		.clk(clk), .arst_n(arst_n), .load(load_data), .way(way_sel), .set(set),
		.wdata(fill_data), .out0(line0), .out1(line1)
	);

	l2_way_array #(.payload_t(lc3b_tag_l2)) tag_array (
		.clk(clk), .arst_n(arst_n), .load(load_tag), .way(way_sel), .set(set),
		.wdata(tag), .out0(tag0), .out1(tag1)
	);

	l2_way_array #(.payload_t(logic)) valid_array (
		.clk(clk), .arst_n(arst_n), .load(load_valid), .way(way_sel), .set(set),
		.wdata(1'b1), .out0(valid0), .out1(valid1)
	);

	// a clear writes zero through the same port.
	l2_way_array #(.payload_t(logic)) dirty_array (
		.clk(clk), .arst_n(arst_n), .load(load_dirty || clear_dirty), .way(way_sel),
		.set(set), .wdata(!clear_dirty), .out0(dirty0), .out1(dirty1)
	);

	// lru bit names the way to evict next.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `L2_SETS; i++)
				lru[i] <= 1'b0;
		end else if (load_lru) begin
			lru[set] <= !way_sel;
		end
	end

	assign line_out = way_sel ? line1 : line0;
	assign valid = way_sel ? valid1 : valid0;
	assign dirty = way_sel ? dirty1 : dirty0;
	assign victim_tag = way_sel ? tag1 : tag0;

	assign mem_rdata = line_out;
	assign pmem_wdata = line_out;

	// line aligned, victim for writeback or request for fill.
	assign pmem_address = pmem_addr_sel ?
		{victim_tag, set, {offset_bits{1'b0}}} :
		{mem_address[`L2_TAG_HI:`L2_INDEX_LO], {offset_bits{1'b0}}};

endmodule : cache_datapath_l2

`default_nettype wire

// File: hdl/l2_defs.svh
`ifndef L2_DEFS_SVH
`define L2_DEFS_SVH

// number of sets in the l2.
`define L2_SETS 32

// set index field of a byte address.
`define L2_INDEX_HI 9
`define L2_INDEX_LO 5

// byte offset within a 256-bit line.
`define L2_OFFSET_HI 4
`define L2_OFFSET_LO 0

// tag field, everything above the index.
`define L2_TAG_HI 15
`define L2_TAG_LO 10

`endif

// File: hdl/l2_port_arbiter.sv
`default_nettype none

module l2_port_arbiter import lc3b_types::*; (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic i_req,
	input wire logic i_write,
	input wire lc3b_word i_address,
	input wire lc3b_burst i_wdata,
	input wire logic d_req,
	input wire logic d_write,
	input wire lc3b_word d_address,
	input wire lc3b_burst d_wdata,
	input wire logic l2_resp,
	output logic i_resp,
	output logic d_resp,
	output logic l2_req,
	output logic l2_write,
	output lc3b_word l2_address,
	output lc3b_burst l2_wdata
);

	logic i_pend;
	logic d_pend;
	logic busy;
	logic grant;
	logic last_d;
	logic pick_d;
	logic i_write_q;
	logic d_write_q;
	lc3b_word i_address_q;
	lc3b_word d_address_q;
	lc3b_burst i_wdata_q;
	lc3b_burst d_wdata_q;

	// on a tie, the port not served last wins.
	assign pick_d = d_pend && (!i_pend || !last_d);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			i_pend <= 1'b0;
			d_pend <= 1'b0;
			busy <= 1'b0;
			grant <= 1'b0;
			last_d <= 1'b0;
			l2_req <= 1'b0;
		end else begin
			l2_req <= 1'b0;
			if (l2_resp) begin
				busy <= 1'b0;
				last_d <= grant;
				if (grant)
					d_pend <= 1'b0;
				else
					i_pend <= 1'b0;
			end else if (!busy && (i_pend || d_pend)) begin
				busy <= 1'b1;
				grant <= pick_d;
				l2_req <= 1'b1;
			end
			if (i_req)
				i_pend <= 1'b1;
			if (d_req)
				d_pend <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (i_req) begin
			i_write_q <= i_write;
			i_address_q <= i_address;
			i_wdata_q <= i_wdata;
		end
		if (d_req) begin
			d_write_q <= d_write;
			d_address_q <= d_address;
			d_wdata_q <= d_wdata;
		end
	end

	// steady while the grant is in flight.
	assign l2_write = grant ? d_write_q : i_write_q;
	assign l2_address = grant ? d_address_q : i_address_q;
	assign l2_wdata = grant ? d_wdata_q : i_wdata_q;

	assign i_resp = l2_resp && !grant;
	assign d_resp = l2_resp && grant;

endmodule : l2_port_arbiter

`default_nettype wire

// File: hdl/l2_subsystem.sv
`default_nettype none

module l2_subsystem import lc3b_types::*; (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic i_req,
	input wire logic i_write,
	input wire lc3b_word i_address,
	input wire lc3b_burst i_wdata,
	output logic i_resp,
	output lc3b_burst i_rdata,
	input wire logic d_req,
	input wire logic d_write,
	input wire lc3b_word d_address,
	input wire lc3b_burst d_wdata,
	output logic d_resp,
	output lc3b_burst d_rdata,
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_word pmem_address,
	output lc3b_burst pmem_wdata,
	input wire lc3b_burst pmem_rdata,
	input wire logic pmem_resp
);

	logic l2_req;
	logic l2_write;
	logic l2_resp;
	lc3b_word l2_address;
	lc3b_burst l2_wdata;
	lc3b_burst l2_rdata;
	logic tag_hit;
	logic valid;
	logic dirty;
	logic load_data;
	logic load_tag;
	logic load_valid;
	logic load_dirty;
	logic clear_dirty;
	logic load_lru;
	logic cache_in_sel;
	logic pmem_addr_sel;

	l2_port_arbiter arbiter (
		.clk(clk), .arst_n(arst_n),
		.i_req(i_req), .i_write(i_write), .i_address(i_address), .i_wdata(i_wdata),
		.d_req(d_req), .d_write(d_write), .d_address(d_address), .d_wdata(d_wdata),
		.l2_resp(l2_resp), .i_resp(i_resp), .d_resp(d_resp),
		.l2_req(l2_req), .l2_write(l2_write), .l2_address(l2_address), .l2_wdata(l2_wdata)
	);

	cache_control_l2 control (
		.clk(clk), .arst_n(arst_n), .l2_req(l2_req), .l2_write(l2_write),
		.tag_hit(tag_hit), .valid(valid), .dirty(dirty), .pmem_resp(pmem_resp),
		.l2_resp(l2_resp), .pmem_read(pmem_read), .pmem_write(pmem_write),
		.load_data(load_data), .load_tag(load_tag), .load_valid(load_valid),
		.load_dirty(load_dirty), .clear_dirty(clear_dirty), .load_lru(load_lru),
		.cache_in_sel(cache_in_sel), .pmem_addr_sel(pmem_addr_sel)
	);

	cache_datapath_l2 datapath (
		.clk(clk), .arst_n(arst_n), .load_data(load_data), .load_valid(load_valid),
		.load_dirty(load_dirty), .clear_dirty(clear_dirty), .load_lru(load_lru),
		.load_tag(load_tag), .cache_in_sel(cache_in_sel), .pmem_addr_sel(pmem_addr_sel),
		.mem_address(l2_address), .mem_wdata(l2_wdata), .pmem_rdata(pmem_rdata),
		.tag_hit(tag_hit), .valid(valid), .dirty(dirty), .mem_rdata(l2_rdata),
		.pmem_wdata(pmem_wdata), .pmem_address(pmem_address)
	);

	// both requesters see the line, only the strobe is routed.
	assign i_rdata = l2_rdata;
	assign d_rdata = l2_rdata;

endmodule : l2_subsystem

`default_nettype wire

// File: hdl/l2_way_array.sv
`default_nettype none

module l2_way_array import lc3b_types::*; #(
	parameter type payload_t = logic
) (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic load,
	input wire logic way,
	input wire lc3b_set_l2 set,
	input wire payload_t wdata,
	output payload_t out0,
	output payload_t out1
);

	localparam int sets = 2 ** $bits(lc3b_set_l2);

	payload_t mem0 [sets];
	payload_t mem1 [sets];

	// valid and dirty bits rely on this clear.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < sets; i++) begin
				mem0[i] <= '0;
				mem1[i] <= '0;
			end
		end else if (load) begin
			if (way)
				mem1[set] <= wdata;
			else
				mem0[set] <= wdata;
		end
	end

	assign out0 = mem0[set];
	assign out1 = mem1[set];

endmodule : l2_way_array

`default_nettype wire

// File: hdl/lc3b_types.sv
`default_nettype none

package lc3b_types;

	// byte address.
	typedef logic [15:0] lc3b_word;

	// one full cache line.
	typedef logic [255:0] lc3b_burst;

	// tag bits, address [15:10].
	typedef logic [5:0] lc3b_tag_l2;

	// set index, address [9:5].
	typedef logic [4:0] lc3b_set_l2;

endpackage : lc3b_types

`default_nettype wire
